/* source/fwd_pkg.sv */
/*
 * Shared widths, operation codes and stage structs for the pipeline slice.
 * x0 is never a producer; op_writes_rd only reports which opcodes write rd.
 */
package fwd_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int IMM_W     = 16;
    localparam int MUL_SPLIT = XLEN / 2;    // Bit where the multiply splits the multiplier.

    // Value returned on a forwarding miss, easy to spot in waveforms.
    localparam logic [XLEN-1:0] FWD_POISON = 32'hDEADBEEF;

    typedef enum logic [2:0] {
        OP_NOP,
        OP_LI,
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_MUL,
        OP_OUT
    } op_e;

    // Decoded instruction as presented by the issuer.
    typedef struct packed {
        op_e                  op;
        logic [REG_IDX_W-1:0] rd_idx;
        logic [REG_IDX_W-1:0] rs1_idx;
        logic [REG_IDX_W-1:0] rs2_idx;
        logic [IMM_W-1:0]     imm;
    } issue_pkt_t;

    typedef struct packed {
        logic [REG_IDX_W-1:0] reg_idx;
        logic                 stage_uses_reg;   // Operand value is needed this cycle.
    } forwardee_t;

    typedef struct packed {
        logic            use_fwd;
        logic [XLEN-1:0] fwd_val;
    } fwd_result_t;

    typedef struct packed {
        logic [REG_IDX_W-1:0] rd_idx;
        logic                 instr_produces_rd;
        logic                 rd_val_avail;
        logic [XLEN-1:0]      rd_val;
    } forwarder_t;

    // Payload carried from M1 through M2 to W.
    typedef struct packed {
        logic                 valid;
        op_e                  op;
        logic [REG_IDX_W-1:0] rd_idx;
        logic [REG_IDX_W-1:0] rs2_idx;
        logic [XLEN-1:0]      a_val;
        logic [XLEN-1:0]      b_val;
        logic [XLEN-1:0]      result;
    } stage_t;

    function automatic logic op_writes_rd(input op_e op);
        return op inside {OP_LI, OP_ADD, OP_SUB, OP_XOR, OP_MUL};
    endfunction

endpackage : fwd_pkg

/* source/fwd_network.sv */
/*
 * Purely combinational forwarding search, closest producer first.
 * A forwarder must clear instr_produces_rd when its stage is empty or rd is x0.
 */
`timescale 1ns/1ps

module fwd_network
    import fwd_pkg::*;
(
    input  forwardee_t  e_rs1,
    input  forwardee_t  e_rs2,
    input  forwardee_t  m1_rs2,
    input  forwardee_t  m2_rs2,
    input  forwarder_t  m1_fwdr,
    input  forwarder_t  m2_fwdr,
    input  forwarder_t  w_fwdr,
    output fwd_result_t e_rs1_res,
    output fwd_result_t e_rs2_res,
    output fwd_result_t m1_rs2_res,
    output fwd_result_t m2_rs2_res,
    output logic        e_hazard,
    output logic        m1_hazard,
    output logic        m2_hazard
);

    logic e_rs1_hazard;
    logic e_rs2_hazard;

    function automatic logic may_fwd(input forwardee_t fe, input forwarder_t fr);
        return (fe.reg_idx == fr.rd_idx) && fr.instr_produces_rd;
    endfunction

    // The value exists somewhere in the pipe but not yet in a usable form.
    function automatic logic is_hazard(input forwardee_t fe, input forwarder_t fr);
        return !fr.rd_val_avail && fe.stage_uses_reg;
    endfunction

    function automatic fwd_result_t take(input forwarder_t fr);
        fwd_result_t res;
        res.use_fwd = 1'b1;
        res.fwd_val = fr.rd_val;
        return res;
    endfunction

    localparam fwd_result_t NO_FWD = '{use_fwd: 1'b0, fwd_val: FWD_POISON};

    always_comb begin
        e_rs1_res    = NO_FWD;
        e_rs1_hazard = 1'b0;
        if (may_fwd(e_rs1, m1_fwdr)) begin
            e_rs1_res    = take(m1_fwdr);
            e_rs1_hazard = is_hazard(e_rs1, m1_fwdr);
        end else if (may_fwd(e_rs1, m2_fwdr)) begin
            e_rs1_res    = take(m2_fwdr);
            e_rs1_hazard = is_hazard(e_rs1, m2_fwdr);
        end else if (may_fwd(e_rs1, w_fwdr)) begin
            e_rs1_res    = take(w_fwdr);
            e_rs1_hazard = is_hazard(e_rs1, w_fwdr);
        end
    end

    always_comb begin
        e_rs2_res    = NO_FWD;
        e_rs2_hazard = 1'b0;
        if (may_fwd(e_rs2, m1_fwdr)) begin
            e_rs2_res    = take(m1_fwdr);
            e_rs2_hazard = is_hazard(e_rs2, m1_fwdr);
        end else if (may_fwd(e_rs2, m2_fwdr)) begin
            e_rs2_res    = take(m2_fwdr);
            e_rs2_hazard = is_hazard(e_rs2, m2_fwdr);
        end else if (may_fwd(e_rs2, w_fwdr)) begin
            e_rs2_res    = take(w_fwdr);
            e_rs2_hazard = is_hazard(e_rs2, w_fwdr);
        end
    end

    assign e_hazard = e_rs1_hazard || e_rs2_hazard;

    // M1 only sees producers that are older than itself.
    always_comb begin
        m1_rs2_res = NO_FWD;
        m1_hazard  = 1'b0;
        if (may_fwd(m1_rs2, m2_fwdr)) begin
            m1_rs2_res = take(m2_fwdr);
            m1_hazard  = is_hazard(m1_rs2, m2_fwdr);
        end else if (may_fwd(m1_rs2, w_fwdr)) begin
            m1_rs2_res = take(w_fwdr);
            m1_hazard  = is_hazard(m1_rs2, w_fwdr);
        end
    end

    always_comb begin
        m2_rs2_res = NO_FWD;
        m2_hazard  = 1'b0;
        if (may_fwd(m2_rs2, w_fwdr)) begin
            m2_rs2_res = take(w_fwdr);
            m2_hazard  = is_hazard(m2_rs2, w_fwdr);   // W always has its value.
        end
    end

endmodule : fwd_network

/* source/reg_file.sv */
/*
 * 32 x 32 register file, combinational reads, one synchronous write port.
 * Reads do not bypass the write of the same cycle; the W forwarder covers that.
 */
`timescale 1ns/1ps

module reg_file
    import fwd_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [REG_IDX_W-1:0] rd_addr_a,
    input  logic [REG_IDX_W-1:0] rd_addr_b,
    output logic [XLEN-1:0]      rd_data_a,
    output logic [XLEN-1:0]      rd_data_b,
    input  logic                 wr_en,
    input  logic [REG_IDX_W-1:0] wr_addr,
    input  logic [XLEN-1:0]      wr_data
);

    logic [XLEN-1:0] regs [2**REG_IDX_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_IDX_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin   // x0 stays zero.
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule : reg_file

/* source/exec_stage.sv */
/*
 * Execute stage. Operands are reselected every cycle, so a held instruction
 * picks up values as they arrive. MUL operands pass on unmodified to M1.
 */
`timescale 1ns/1ps

module exec_stage
    import fwd_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  issue_pkt_t           issue,
    input  logic                 e_hold,
    input  logic                 m1_hold,
    input  logic [XLEN-1:0]      rs1_rf,
    input  logic [XLEN-1:0]      rs2_rf,
    input  fwd_result_t          e_rs1_res,
    input  fwd_result_t          e_rs2_res,
    output logic [REG_IDX_W-1:0] rs1_idx,
    output logic [REG_IDX_W-1:0] rs2_idx,
    output forwardee_t           e_rs1,
    output forwardee_t           e_rs2,
    output stage_t               e_out
);

    logic            e_valid;
    issue_pkt_t      e_pkt;
    logic            uses_rs;
    logic [XLEN-1:0] a_val;
    logic [XLEN-1:0] b_val;

    // Accept a new packet only when nothing downstream asks E to wait.
    always_ff @(posedge clk) begin
        if (rst) begin
            e_valid <= 1'b0;
        end else if (!(e_hold || m1_hold)) begin
            e_valid <= issue_valid;
            e_pkt   <= issue;
        end
    end

    assign rs1_idx = e_pkt.rs1_idx;
    assign rs2_idx = e_pkt.rs2_idx;

    // OUT only carries rs2 here; its value is settled in M1 and M2.
    assign uses_rs = e_valid && (e_pkt.op inside {OP_ADD, OP_SUB, OP_XOR, OP_MUL});

    assign e_rs1.reg_idx        = e_pkt.rs1_idx;
    assign e_rs1.stage_uses_reg = uses_rs;
    assign e_rs2.reg_idx        = e_pkt.rs2_idx;
    assign e_rs2.stage_uses_reg = uses_rs;

    assign a_val = e_rs1_res.use_fwd ? e_rs1_res.fwd_val : rs1_rf;
    assign b_val = e_rs2_res.use_fwd ? e_rs2_res.fwd_val : rs2_rf;

    always_comb begin
        e_out.valid   = e_valid && !e_hold;   // Bubble into M1 while E waits.
        e_out.op      = e_pkt.op;
        e_out.rd_idx  = e_pkt.rd_idx;
        e_out.rs2_idx = e_pkt.rs2_idx;
        e_out.a_val   = a_val;
        e_out.b_val   = b_val;
        case (e_pkt.op)
            OP_LI:   e_out.result = {{(XLEN-IMM_W){1'b0}}, e_pkt.imm};
            OP_ADD:  e_out.result = a_val + b_val;
            OP_SUB:  e_out.result = a_val - b_val;
            OP_XOR:  e_out.result = a_val ^ b_val;
            default: e_out.result = '0;   // MUL finishes later, NOP and OUT have none.
        endcase
    end

endmodule : exec_stage

/* source/mem_pipe.sv */
/*
 * M1, M2 and W stages. The multiply is split at MUL_SPLIT across M1 and M2.
 * W has no hold, so a held M1 is only ever followed by a bubble in M2.
 */
`timescale 1ns/1ps

module mem_pipe
    import fwd_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  stage_t               e_out,
    input  fwd_result_t          m1_rs2_res,
    input  fwd_result_t          m2_rs2_res,
    input  logic                 m1_hazard,
    output forwardee_t           m1_rs2,
    output forwardee_t           m2_rs2,
    output forwarder_t           m1_fwdr,
    output forwarder_t           m2_fwdr,
    output forwarder_t           w_fwdr,
    output logic                 wb_en,
    output logic [REG_IDX_W-1:0] wb_addr,
    output logic [XLEN-1:0]      wb_data,
    output logic                 out_valid,
    output logic [XLEN-1:0]      out_data
);

    stage_t          m1;
    stage_t          m2;
    stage_t          w;
    stage_t          m1_adv;
    stage_t          m2_adv;
    logic [XLEN-1:0] mul_hi;

    function automatic forwarder_t publish(input stage_t s, input logic avail);
        forwarder_t fr;
        fr.rd_idx            = s.rd_idx;
        fr.instr_produces_rd = s.valid && op_writes_rd(s.op) && (s.rd_idx != '0);
        fr.rd_val_avail      = avail;
        fr.rd_val            = s.result;
        return fr;
    endfunction

    assign m1_rs2.reg_idx        = m1.rs2_idx;
    assign m1_rs2.stage_uses_reg = m1.valid && (m1.op == OP_OUT);
    assign m2_rs2.reg_idx        = m2.rs2_idx;
    assign m2_rs2.stage_uses_reg = m2.valid && (m2.op == OP_OUT);

    always_comb begin
        m1_adv = m1;
        if (m1.op == OP_MUL) begin
            // Low partial product, kept in the result field for M2.
            m1_adv.result = m1.a_val * {{(XLEN-MUL_SPLIT){1'b0}}, m1.b_val[MUL_SPLIT-1:0]};
        end
        if ((m1.op == OP_OUT) && m1_rs2_res.use_fwd) begin
            m1_adv.b_val = m1_rs2_res.fwd_val;
        end
    end

    assign mul_hi = m2.a_val * {{MUL_SPLIT{1'b0}}, m2.b_val[XLEN-1:MUL_SPLIT]};

    always_comb begin
        m2_adv = m2;
        if (m2.op == OP_MUL) begin
            m2_adv.result = m2.result + {mul_hi[XLEN-MUL_SPLIT-1:0], {MUL_SPLIT{1'b0}}};
        end
        if ((m2.op == OP_OUT) && m2_rs2_res.use_fwd) begin
            m2_adv.b_val = m2_rs2_res.fwd_val;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m1.valid <= 1'b0;
            m2.valid <= 1'b0;
            w.valid  <= 1'b0;
        end else begin
            if (!m1_hazard) begin
                m1 <= e_out;
            end
            m2       <= m1_adv;
            m2.valid <= m1.valid && !m1_hazard;   // Held M1 leaves a bubble behind.
            w        <= m2_adv;
        end
    end

    // A product is only whole once it reaches W.
    assign m1_fwdr = publish(m1, m1.op != OP_MUL);
    assign m2_fwdr = publish(m2, m2.op != OP_MUL);
    assign w_fwdr  = publish(w, 1'b1);

    assign wb_en   = w_fwdr.instr_produces_rd;
    assign wb_addr = w.rd_idx;
    assign wb_data = w.result;

    assign out_valid = m2.valid && (m2.op == OP_OUT);
    assign out_data  = m2_adv.b_val;

endmodule : mem_pipe

/* source/pipe_slice_top.sv */
/*
 * Pipeline slice top. The issuer must hold its packet while stall is high;
 * the OUT port has no back-pressure.
 */
`timescale 1ns/1ps

module pipe_slice_top
    import fwd_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            issue_valid,
    input  issue_pkt_t      issue,
    output logic            stall,
    output logic            out_valid,
    output logic [XLEN-1:0] out_data
);

    logic [REG_IDX_W-1:0] rs1_idx, rs2_idx;
    logic [XLEN-1:0]      rs1_rf, rs2_rf;
    forwardee_t           e_rs1, e_rs2, m1_rs2, m2_rs2;
    fwd_result_t          e_rs1_res, e_rs2_res, m1_rs2_res, m2_rs2_res;
    forwarder_t           m1_fwdr, m2_fwdr, w_fwdr;
    stage_t               e_out;
    logic                 e_hazard, m1_hazard;
    logic                 wb_en;
    logic [REG_IDX_W-1:0] wb_addr;
    logic [XLEN-1:0]      wb_data;

    assign stall = e_hazard || m1_hazard;

    exec_stage u_exec (
        .clk, .rst, .issue_valid, .issue,
        .e_hold(e_hazard), .m1_hold(m1_hazard),
        .rs1_rf, .rs2_rf, .e_rs1_res, .e_rs2_res,
        .rs1_idx, .rs2_idx, .e_rs1, .e_rs2, .e_out
    );

    mem_pipe u_mem (
        .clk, .rst, .e_out, .m1_rs2_res, .m2_rs2_res, .m1_hazard,
        .m1_rs2, .m2_rs2, .m1_fwdr, .m2_fwdr, .w_fwdr,
        .wb_en, .wb_addr, .wb_data, .out_valid, .out_data
    );

    // W always has its value, so M2 never waits.
    fwd_network u_fwd (
        .e_rs1, .e_rs2, .m1_rs2, .m2_rs2, .m1_fwdr, .m2_fwdr, .w_fwdr,
        .e_rs1_res, .e_rs2_res, .m1_rs2_res, .m2_rs2_res,
        .e_hazard, .m1_hazard, .m2_hazard()
    );

    reg_file u_rf (
        .clk, .rst,
        .rd_addr_a(rs1_idx), .rd_addr_b(rs2_idx),
        .rd_data_a(rs1_rf), .rd_data_b(rs2_rf),
        .wr_en(wb_en), .wr_addr(wb_addr), .wr_data(wb_data)
    );

endmodule : pipe_slice_top

/* verification/pipe_slice_props.sv */
/*
 * Concurrent checks on stall, hazards and the OUT port, bound into pipe_slice_top.
 * err_count counts failed properties so far.
 */
`timescale 1ns/1ps

module fwd_props (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic e_hazard,
    input logic m1_hazard,
    input logic m1_out,
    input logic out_valid
);

    int err_count = 0;

    stall_from_hazard: assert property (@(posedge clk) disable iff (rst)
        stall |-> (e_hazard || m1_hazard))
        else begin
            err_count++;
            $error("stall is high while neither E nor M1 has a hazard");
        end

    // A MUL result reaches W at most two cycles after its consumer starts to wait.
    stall_is_short: assert property (@(posedge clk) disable iff (rst)
        stall [*2] |=> !stall)
        else begin
            err_count++;
            $error("stall stayed high for more than two cycles");
        end

    empty_after_reset: assert property (@(posedge clk) rst |=> (!stall && !out_valid))
        else begin
            err_count++;
            $error("stall or out_valid is high right after reset");
        end

    // A second pulse needs an OUT that leaves M1 in this cycle.
    single_out_pulse: assert property (@(posedge clk) disable iff (rst)
        out_valid && !(m1_out && !m1_hazard) |=> !out_valid)
        else begin
            err_count++;
            $error("out_valid stayed high without a second OUT behind it");
        end

endmodule : fwd_props

bind pipe_slice_top fwd_props u_props (
    .clk, .rst, .stall, .e_hazard, .m1_hazard,
    .m1_out(m1_rs2.stage_uses_reg),
    .out_valid
);

/* verification/pipe_slice_tb.sv */
/*
 * Directed and random programs over x0..x7, checked against an in-order register model.
 * Each packet is held while stall is high; OUT values are compared at out_valid.
 */
`timescale 1ns/1ps

module pipe_slice_tb
    import fwd_pkg::*;
();

    localparam int WAIT_LIMIT  = 64;
    localparam int RAND_INSTRS = 300;

    logic            clk = 1'b0;
    logic            rst;
    logic            issue_valid;
    issue_pkt_t      issue;
    logic            stall;
    logic            out_valid;
    logic [XLEN-1:0] out_data;

    logic [XLEN-1:0] model_regs [8];
    logic [XLEN-1:0] expected [$];
    logic [XLEN-1:0] exp_val;
    int              outs_issued = 0;
    int              outs_seen = 0;

    pipe_slice_top DUT (.clk, .rst, .issue_valid, .issue, .stall, .out_valid, .out_data);

    always #2 clk = ~clk;

    task automatic report_and_stop(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    // Architectural effect of one instruction, in program order.
    task automatic execute_in_model(input issue_pkt_t p);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = model_regs[p.rs1_idx[2:0]];
        b = model_regs[p.rs2_idx[2:0]];
        case (p.op)
            OP_LI:  model_regs[p.rd_idx[2:0]] = {{(XLEN-IMM_W){1'b0}}, p.imm};
            OP_ADD: model_regs[p.rd_idx[2:0]] = a + b;
            OP_SUB: model_regs[p.rd_idx[2:0]] = a - b;
            OP_XOR: model_regs[p.rd_idx[2:0]] = a ^ b;
            OP_MUL: model_regs[p.rd_idx[2:0]] = a * b;
            OP_OUT: begin
                expected.push_back(b);
                outs_issued++;
            end
            default: ;
        endcase
        model_regs[0] = '0;   // x0 reads as zero whatever was written.
    endtask

    task automatic send(input op_e op, input int rd, input int rs1, input int rs2,
                        input logic [IMM_W-1:0] imm = '0);
        int waited;
        issue_valid   = 1'b1;
        issue.op      = op;
        issue.rd_idx  = REG_IDX_W'(rd);
        issue.rs1_idx = REG_IDX_W'(rs1);
        issue.rs2_idx = REG_IDX_W'(rs2);
        issue.imm     = imm;
        waited = 0;
        @(negedge clk);
        while (stall) begin
            waited++;
            if (waited > WAIT_LIMIT) report_and_stop("stall stayed high, the pipeline is stuck");
            @(negedge clk);
        end
        @(posedge clk);   // Accepted at this edge.
        #1;
        issue_valid = 1'b0;
        execute_in_model(issue);
    endtask

    function automatic op_e pick_op(input int k);
        case (k)
            0:       return OP_LI;
            1:       return OP_ADD;
            2:       return OP_SUB;
            3:       return OP_XOR;
            4:       return OP_MUL;
            default: return OP_OUT;
        endcase
    endfunction

    always @(negedge clk) begin
        if (!rst) begin
            assert (DUT.u_props.err_count == 0)
                else report_and_stop("a bound property on the pipeline failed");
            if (out_valid) begin
                assert (expected.size() != 0)
                    else report_and_stop("out_valid pulsed with no OUT outstanding");
                exp_val = expected.pop_front();
                outs_seen++;
                assert (out_data === exp_val)
                    else report_and_stop($sformatf("FAILED out_data: expected %08h, actual %08h",
                                                   exp_val, out_data));
            end
        end
    end

    initial begin
        int waited;
        int rd;
        int rs1;
        int rs2;
        int k;
        void'($urandom(32'hf660434d));
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        for (int r = 0; r < 8; r++) model_regs[r] = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (!stall && !out_valid)
            else report_and_stop("stall or out_valid is high right after reset");
        @(posedge clk);
        #1;
        for (int r = 1; r < 8; r++) send(OP_LI, r, 0, 0, IMM_W'($urandom));
        // Dependent ALU chain through M1, M2 and W.
        send(OP_ADD, 1, 1, 2);
        send(OP_SUB, 3, 1, 2);
        send(OP_XOR, 4, 3, 1);
        send(OP_ADD, 5, 4, 3);
        send(OP_OUT, 0, 0, 5);
        send(OP_OUT, 0, 0, 4);
        // ALU right behind a MUL, then OUTs one and two places behind a MUL.
        send(OP_MUL, 6, 1, 2);
        send(OP_ADD, 7, 6, 3);
        send(OP_OUT, 0, 0, 7);
        send(OP_MUL, 2, 5, 6);
        send(OP_OUT, 0, 0, 2);
        send(OP_MUL, 3, 2, 4);
        send(OP_XOR, 1, 1, 5);
        send(OP_OUT, 0, 0, 3);
        // x0 must ignore both writes.
        send(OP_LI, 0, 0, 0, 16'hbeef);
        send(OP_ADD, 0, 1, 2);
        send(OP_OUT, 0, 0, 0);
        for (int i = 0; i < RAND_INSTRS; i++) begin
            k   = $urandom_range(5, 0);
            rd  = $urandom_range(7, 0);
            rs1 = $urandom_range(7, 0);
            rs2 = $urandom_range(7, 0);
            send(pick_op(k), rd, rs1, rs2, IMM_W'($urandom));
        end
        waited = 0;
        while (outs_seen < outs_issued) begin
            waited++;
            if (waited > WAIT_LIMIT) report_and_stop("not every OUT reached the output port");
            @(posedge clk);
        end
        repeat (8) @(posedge clk);   // Room for a stray out_valid pulse.
        if (outs_seen == outs_issued) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_and_stop($sformatf("FAILED outs_seen: expected %08h, actual %08h",
                                      outs_issued, outs_seen));
        end
    end

endmodule : pipe_slice_tb

/* build.f */
source/fwd_pkg.sv
source/fwd_network.sv
source/reg_file.sv
source/exec_stage.sv
source/mem_pipe.sv
source/pipe_slice_top.sv
verification/pipe_slice_props.sv
verification/pipe_slice_tb.sv
